// File: all.f
+incdir+hw
hw/uart_debug_pkg.sv
hw/dbg_mem_if.sv
hw/uart_rx_deserializer.sv
hw/debug_cmd_engine.sv
hw/debug_byte_mem.sv
hw/uart_tx_serializer.sv
hw/uart_debug_top.sv
sim/tb_uart_debug.sv

// File: sim/uart_debug_cases.txt
// op addr len d0..d15 in hex; op 0 challenge, 1 write, 2 read, 3 junk byte d0, 4 bad frame d0
// op 5 random write and read pairs with len as the count, op f ends; read data is expected data
// Challenge after reset
0 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// Write then read back
1 10 4 de ad be ef 00 00 00 00 00 00 00 00 00 00 00 00
2 10 4 de ad be ef 00 00 00 00 00 00 00 00 00 00 00 00
// Wrap at the top of memory, upper header bytes set
1 ffffffff000000fd 00ab000000000006 a1 b2 c3 d4 e5 f6 00 00 00 00 00 00 00 00 00 00
2 fd 6 a1 b2 c3 d4 e5 f6 00 00 00 00 00 00 00 00 00 00
2 7700000000000000 0000000100000003 d4 e5 f6 00 00 00 00 00 00 00 00 00 00 00 00 00
// Junk and broken frames are ignored
3 0 0 55 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
4 0 0 12 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
0 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
2 10 2 de ad 00 00 00 00 00 00 00 00 00 00 00 00 00 00
3 0 0 a0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
4 0 0 06 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// Zero lengths
2 20 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
1 30 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// Full sixteen byte burst
1 40 10 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff
2 40 10 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff
// Random pairs
5 0 14 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
f

// File: sim/tb_uart_debug.sv
// Testbench for the UART debug server with serial driver, monitor and shadow memory
`timescale 1ns/1ps
`default_nettype none

`include "uart_debug_settings.svh"

module tb_uart_debug;

  import uart_debug_pkg::*;

  localparam int CPB        = `DBG_CLKS_PER_BIT;
  localparam int AW         = `DBG_MEM_ADDR_BITS;
  localparam int MEM_SIZE   = 1 << AW;
  localparam int FRAME_CYC  = 10 * CPB;
  localparam int REPLY_WAIT = 3 * FRAME_CYC;
  localparam int CLK_NS     = 20;
  localparam int REC_WORDS  = 19;
  localparam int MAX_RECS   = 32;

  localparam int OP_CHALLENGE = 0;
  localparam int OP_WRITE     = 1;
  localparam int OP_READ      = 2;
  localparam int OP_JUNK      = 3;
  localparam int OP_BAD_FRAME = 4;
  localparam int OP_RANDOM    = 5;
  localparam int OP_END       = 15;

  logic            clk;
  logic            rst;
  logic            rx_line;
  logic            tx_line;
  logic [63:0]     case_mem [MAX_RECS * REC_WORDS];
  logic [7:0]      shadow [MEM_SIZE];
  logic [7:0]      payload [16];
  logic [7:0]      reply_q [$];
  longint unsigned wd_ns = 0;

  uart_debug_top dut_i (
    .clk       (clk),
    .rst_i     (rst),
    .uart_rx_i (rx_line),
    .uart_tx_o (tx_line)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic fail_run();
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped at the first error");
  endtask

  initial begin : watchdog
    wait (wd_ns != 0);
    #(wd_ns);
    $display("Timeout after %0d ns, the DUT stopped answering", wd_ns);
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

  //////////////////////////////////////////////////
  // Serial driver and monitor
  //////////////////////////////////////////////////

  // Frame bits go out LSB first, one bit time each
  task automatic send_bits(input logic [9:0] frame);
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rx_line <= frame[i];
      repeat (CPB - 1) @(posedge clk);
    end
  endtask

  task automatic send_byte(input logic [7:0] data);
    send_bits({1'b1, data, 1'b0});
  endtask

  // Low stop bit, then back to idle for one bit time
  task automatic send_bad_frame(input logic [7:0] data);
    send_bits({1'b0, data, 1'b0});
    @(posedge clk);
    rx_line <= 1'b1;
    repeat (CPB - 1) @(posedge clk);
  endtask

  initial begin : serial_monitor
    logic [7:0] rx_byte;
    forever begin
      @(negedge clk);
      if (!rst && tx_line === 1'b0) begin
        // Middle of the start bit, then one bit time per step
        repeat (CPB / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (CPB) @(negedge clk);
          rx_byte[i] = tx_line;
        end
        repeat (CPB) @(negedge clk);
        assert (tx_line === 1'b1) else begin
          $display("MISMATCH at %0t ns: stop bit of a reply frame on uart_tx_o was low",
                   $time);
          fail_run();
        end
        reply_q.push_back(rx_byte);
      end
    end
  end

  //////////////////////////////////////////////////
  // Reply checks
  //////////////////////////////////////////////////

  task automatic expect_reply(input logic [7:0] exp, input string what);
    int         waited;
    logic [7:0] got;
    waited = 0;
    while (reply_q.size() == 0 && waited < REPLY_WAIT) begin
      @(negedge clk);
      waited++;
    end
    assert (reply_q.size() != 0) else begin
      $display("No reply byte arrived for %s within %0d cycles", what, REPLY_WAIT);
      fail_run();
    end
    got = reply_q.pop_front();
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s expected 0x%02h got 0x%02h", $time, what, exp, got);
      fail_run();
    end
  endtask

  task automatic expect_quiet(input int frames, input string what);
    repeat (frames * FRAME_CYC) @(negedge clk);
    assert (reply_q.size() == 0) else begin
      $display("A byte 0x%02h came back after %s, where no reply was due", reply_q[0], what);
      fail_run();
    end
  endtask

  task automatic check_idle_line();
    repeat (2 * FRAME_CYC) begin
      @(negedge clk);
      assert (tx_line === 1'b1) else begin
        $display("MISMATCH at %0t ns: uart_tx_o left idle high after reset", $time);
        fail_run();
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Commands
  //////////////////////////////////////////////////

  task automatic send_header(input logic [7:0] cmd, input logic [63:0] addr,
                             input logic [63:0] len);
    send_byte(cmd);
    for (int i = 0; i < HDR_ADDR_BYTES; i++) begin
      send_byte(addr[8*i +: 8]);
    end
    for (int i = 0; i < HDR_LEN_BYTES; i++) begin
      send_byte(len[8*i +: 8]);
    end
  endtask

  task automatic do_write(input logic [63:0] addr, input logic [63:0] len);
    int            n;
    logic [AW-1:0] a;
    n = int'(len[LEN_BITS-1:0]);
    assert (n <= 16) else begin
      $display("Write length %0d is above the sixteen payload bytes", n);
      fail_run();
    end
    send_header(CMD_WRITE, addr, len);
    for (int i = 0; i < n; i++) begin
      send_byte(payload[i]);
      // Address keeps only its low bits and wraps
      a = addr[AW-1:0] + AW'(i);
      shadow[a] = payload[i];
    end
    expect_reply(BYTE_ACK, "write ACK");
    expect_reply(BYTE_EOT, "write EOT");
  endtask

  task automatic do_read(input logic [63:0] addr, input logic [63:0] len,
                         input bit from_file);
    int            n;
    logic [AW-1:0] a;
    n = int'(len[LEN_BITS-1:0]);
    assert (n <= 16) else begin
      $display("Read length %0d is above the sixteen payload bytes", n);
      fail_run();
    end
    send_header(CMD_READ, addr, len);
    expect_reply(BYTE_ACK, "read ACK");
    for (int i = 0; i < n; i++) begin
      a = addr[AW-1:0] + AW'(i);
      if (from_file) begin
        assert (payload[i] === shadow[a]) else begin
          $display("MISMATCH at %0t ns: case file byte %0d expected 0x%02h, model has 0x%02h",
                   $time, i, payload[i], shadow[a]);
          fail_run();
        end
      end
      expect_reply(shadow[a], "read data");
    end
    expect_reply(BYTE_EOT, "read EOT");
  endtask

  task automatic run_random_pairs(input int count);
    logic [63:0] addr;
    logic [63:0] len;
    for (int k = 0; k < count; k++) begin
      addr = {$urandom, $urandom};
      len  = {$urandom, 16'($urandom), 16'(1 + $urandom % 16)};
      for (int i = 0; i < 16; i++) begin
        payload[i] = 8'($urandom);
      end
      do_write(addr, len);
      do_read(addr, len, 1'b0);
    end
  endtask

  // Serial bytes both ways plus quiet gaps, per record
  function automatic longint unsigned count_bytes();
    longint unsigned total;
    int              base;
    int              op;
    int              n;
    total = 8;
    for (int r = 0; r < MAX_RECS; r++) begin
      base = r * REC_WORDS;
      if ($isunknown(case_mem[base]) || int'(case_mem[base]) == OP_END) begin
        break;
      end
      op = int'(case_mem[base]);
      n  = int'(case_mem[base + 2][LEN_BITS-1:0]);
      case (op)
        OP_WRITE, OP_READ: total += 19 + n;
        OP_RANDOM:         total += 70 * n;
        default:           total += 4;
      endcase
    end
    return total;
  endfunction

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    int          base;
    int          op;
    logic [63:0] addr;
    logic [63:0] len;
    rst     = 1'b1;
    rx_line = 1'b1;
    void'($urandom(32'ha3905306));
    $readmemh("sim/uart_debug_cases.txt", case_mem);
    assert (!$isunknown(case_mem[0])) else begin
      $display("Case file sim/uart_debug_cases.txt could not be read");
      fail_run();
    end
    wd_ns = 2 * count_bytes() * FRAME_CYC * CLK_NS;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    check_idle_line();
    for (int r = 0; r < MAX_RECS; r++) begin
      base = r * REC_WORDS;
      if ($isunknown(case_mem[base]) || int'(case_mem[base]) == OP_END) begin
        break;
      end
      op   = int'(case_mem[base]);
      addr = case_mem[base + 1];
      len  = case_mem[base + 2];
      for (int i = 0; i < 16; i++) begin
        payload[i] = case_mem[base + 3 + i][7:0];
      end
      case (op)
        OP_CHALLENGE: begin
          send_byte(BYTE_ACK);
          expect_reply(BYTE_ACK, "challenge reply");
          expect_quiet(2, "challenge reply");
        end
        OP_WRITE:  do_write(addr, len);
        OP_READ:   do_read(addr, len, 1'b1);
        OP_JUNK: begin
          send_byte(payload[0]);
          expect_quiet(2, "junk byte");
        end
        OP_BAD_FRAME: begin
          send_bad_frame(payload[0]);
          expect_quiet(2, "bad frame");
        end
        OP_RANDOM: run_random_pairs(int'(len[LEN_BITS-1:0]));
        default: begin
          $display("Case file record %0d has unknown operation %0d", r, op);
          fail_run();
        end
      endcase
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/uart_debug_top.sv
// UART debug server top level: receiver, command engine, memory, transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_debug_top (
  input  wire logic clk,
  input  wire logic rst_i,
  input  wire logic uart_rx_i,
  output logic      uart_tx_o
);

  logic       rx_valid;
  logic [7:0] rx_data;
  logic       tx_start;
  logic [7:0] tx_data;
  logic       tx_busy;

  dbg_mem_if mem_bus ();

  //////////////////////////////////////////////////
  // Pipeline stages
  //////////////////////////////////////////////////

  uart_rx_deserializer rx_deser_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .rxd_i      (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_data_o  (rx_data)
  );

  debug_cmd_engine cmd_engine_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .rx_valid_i (rx_valid),
    .rx_data_i  (rx_data),
    .tx_busy_i  (tx_busy),
    .tx_start_o (tx_start),
    .tx_data_o  (tx_data),
    .mem        (mem_bus.engine)
  );

  debug_byte_mem byte_mem_i (
    .clk (clk),
    .mem (mem_bus.mem)
  );

  uart_tx_serializer tx_ser_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .tx_start_i (tx_start),
    .tx_data_i  (tx_data),
    .tx_busy_o  (tx_busy),
    .txd_o      (uart_tx_o)
  );

endmodule

`default_nettype wire

// File: hw/uart_tx_serializer.sv
// UART transmitter that shifts out start, eight data and stop bits
`timescale 1ns/1ps
`default_nettype none

`include "uart_debug_settings.svh"

module uart_tx_serializer (
  input  wire logic       clk,
  input  wire logic       rst_i,
  input  wire logic       tx_start_i,
  input  wire logic [7:0] tx_data_i,
  output logic            tx_busy_o,
  output logic            txd_o
);

  localparam int CLKS       = `DBG_CLKS_PER_BIT;
  localparam int CNT_W      = $clog2(CLKS);
  localparam int FRAME_BITS = 10;

  logic [CNT_W-1:0]      cnt_q;
  logic [3:0]            bit_q;
  logic [FRAME_BITS-1:0] frame_q;
  logic                  load;
  logic                  bit_end;

  assign load    = tx_start_i && !tx_busy_o;
  assign bit_end = tx_busy_o && (cnt_q == CNT_W'(CLKS - 1));

  //////////////////////////////////////////////////
  // Bit timing
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      tx_busy_o <= 1'b0;
      cnt_q     <= '0;
      bit_q     <= '0;
    end else if (load) begin
      tx_busy_o <= 1'b1;
      cnt_q     <= '0;
      bit_q     <= '0;
    end else if (bit_end) begin
      cnt_q <= '0;
      // Busy drops as the stop bit ends
      if (bit_q == 4'(FRAME_BITS - 1)) begin
        tx_busy_o <= 1'b0;
      end else begin
        bit_q <= bit_q + 1'b1;
      end
    end else if (tx_busy_o) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Stop, data LSB first, start
  always_ff @(posedge clk) begin
    if (load) begin
      frame_q <= {1'b1, tx_data_i, 1'b0};
    end else if (bit_end) begin
      frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
    end
  end

  // Line idles high
  assign txd_o = tx_busy_o ? frame_q[0] : 1'b1;

endmodule

`default_nettype wire

// File: hw/debug_byte_mem.sv
// Local byte memory with synchronous write and one-cycle registered read
`timescale 1ns/1ps
`default_nettype none

`include "uart_debug_settings.svh"

module debug_byte_mem (
  input wire logic clk,
  dbg_mem_if.mem   mem
);

  localparam int DEPTH = 1 << `DBG_MEM_ADDR_BITS;

  logic [7:0] mem_q [DEPTH];

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // One port, so a request is either a write or a read
  always_ff @(posedge clk) begin
    if (mem.req) begin
      if (mem.we) begin
        mem_q[mem.addr] <= mem.wdata;
      end else begin
        // Held until the next read
        mem.rdata <= mem_q[mem.addr];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/debug_cmd_engine.sv
// Debug command FSM: parses headers, drives memory access and response bytes
`timescale 1ns/1ps
`default_nettype none

`include "uart_debug_settings.svh"

module debug_cmd_engine (
  input  wire logic       clk,
  input  wire logic       rst_i,
  input  wire logic       rx_valid_i,
  input  wire logic [7:0] rx_data_i,
  input  wire logic       tx_busy_i,
  output logic            tx_start_o,
  output logic [7:0]      tx_data_o,
  dbg_mem_if.engine       mem
);

  import uart_debug_pkg::*;

  localparam int AW        = `DBG_MEM_ADDR_BITS;
  localparam int HDR_BYTES = HDR_ADDR_BYTES + HDR_LEN_BYTES;
  localparam int HC_W      = $clog2(HDR_BYTES);
  // Wide enough for either header field
  localparam int FIELD_W   = 8 * HDR_ADDR_BYTES;

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_HDR     = 3'd1;
  localparam logic [2:0] ST_ACK     = 3'd2;
  localparam logic [2:0] ST_RD_REQ  = 3'd3;
  localparam logic [2:0] ST_RD_SEND = 3'd4;
  localparam logic [2:0] ST_WR_DATA = 3'd5;
  localparam logic [2:0] ST_EOT     = 3'd6;

  logic [2:0]          state_q;
  logic [2:0]          state_d;
  logic                cmd_q;
  logic                rd_q;
  logic [HC_W-1:0]     hdr_cnt_q;
  logic [AW-1:0]       addr_q;
  logic [LEN_BITS-1:0] len_q;

  logic                is_cmd;
  logic                hdr_in_addr;
  logic                hdr_last;
  logic [HC_W-1:0]     field_idx;
  logic [FIELD_W-1:0]  byte_shift;
  logic                last_byte;
  logic                tx_free;
  logic                send;
  logic [7:0]          send_byte;
  logic                advance;

  //////////////////////////////////////////////////
  // Header assembly
  //////////////////////////////////////////////////

  assign is_cmd      = (rx_data_i == CMD_READ) || (rx_data_i == CMD_WRITE);
  assign hdr_in_addr = hdr_cnt_q < HC_W'(HDR_ADDR_BYTES);
  assign hdr_last    = hdr_cnt_q == HC_W'(HDR_BYTES - 1);
  assign field_idx   = hdr_in_addr ? hdr_cnt_q : hdr_cnt_q - HC_W'(HDR_ADDR_BYTES);
  // Upper header bytes land above the kept bits and vanish
  assign byte_shift  = FIELD_W'(rx_data_i) << {field_idx, 3'b000};

  assign last_byte = len_q == LEN_BITS'(1);
  // Start pulse in flight counts as busy
  assign tx_free   = !tx_busy_i && !tx_start_o;

  assign mem.addr  = addr_q;
  assign mem.wdata = rx_data_i;

  //////////////////////////////////////////////////
  // Next state and strobes
  //////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    send      = 1'b0;
    send_byte = BYTE_ACK;
    advance   = 1'b0;
    mem.req   = 1'b0;
    mem.we    = 1'b0;
    case (state_q)
      ST_IDLE: begin
        // Anything else is ignored
        if (rx_valid_i && rx_data_i == BYTE_ACK) begin
          state_d = ST_ACK;
        end else if (rx_valid_i && is_cmd) begin
          state_d = ST_HDR;
        end
      end
      ST_HDR: begin
        if (rx_valid_i && hdr_last) begin
          state_d = ST_ACK;
        end
      end
      ST_ACK: begin
        if (tx_free) begin
          send = 1'b1;
          if (!cmd_q) begin
            state_d = ST_IDLE;
          end else if (len_q == '0) begin
            state_d = ST_EOT;
          end else begin
            state_d = rd_q ? ST_RD_REQ : ST_WR_DATA;
          end
        end
      end
      ST_RD_REQ: begin
        // Fetch overlaps the previous byte on the line
        mem.req = 1'b1;
        state_d = ST_RD_SEND;
      end
      ST_RD_SEND: begin
        if (tx_free) begin
          send      = 1'b1;
          send_byte = mem.rdata;
          advance   = 1'b1;
          state_d   = last_byte ? ST_EOT : ST_RD_REQ;
        end
      end
      ST_WR_DATA: begin
        if (rx_valid_i) begin
          mem.req = 1'b1;
          mem.we  = 1'b1;
          advance = 1'b1;
          if (last_byte) begin
            state_d = ST_EOT;
          end
        end
      end
      ST_EOT: begin
        if (tx_free) begin
          send      = 1'b1;
          send_byte = BYTE_EOT;
          state_d   = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      cmd_q      <= 1'b0;
      rd_q       <= 1'b0;
      hdr_cnt_q  <= '0;
      addr_q     <= '0;
      len_q      <= '0;
      tx_start_o <= 1'b0;
    end else begin
      state_q    <= state_d;
      tx_start_o <= send;
      if (state_q == ST_IDLE && rx_valid_i) begin
        cmd_q     <= is_cmd;
        rd_q      <= rx_data_i == CMD_READ;
        hdr_cnt_q <= '0;
        addr_q    <= '0;
        len_q     <= '0;
      end
      if (state_q == ST_HDR && rx_valid_i) begin
        hdr_cnt_q <= hdr_cnt_q + 1'b1;
        if (hdr_in_addr) begin
          addr_q <= addr_q | byte_shift[AW-1:0];
        end else begin
          len_q <= len_q | byte_shift[LEN_BITS-1:0];
        end
      end
      // Address wraps at the memory size
      if (advance) begin
        addr_q <= addr_q + 1'b1;
        len_q  <= len_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      tx_data_o <= send_byte;
    end
  end

  a_tx_start_when_free: assert property (
    @(posedge clk) disable iff (rst_i) tx_start_o |-> !tx_busy_i
  ) else $error("tx_start_o raised while transmitter busy");

  // Data phase is a command with bytes still outstanding
  a_req_in_data_phase: assert property (
    @(posedge clk) disable iff (rst_i)
      mem.req |-> (cmd_q && len_q != '0)
  ) else $error("memory request outside data phase");

endmodule

`default_nettype wire

// File: hw/uart_rx_deserializer.sv
// UART receiver that samples each bit at its middle and emits byte strobes
`timescale 1ns/1ps
`default_nettype none

`include "uart_debug_settings.svh"

module uart_rx_deserializer (
  input  wire logic  clk,
  input  wire logic  rst_i,
  input  wire logic  rxd_i,
  output logic       rx_valid_o,
  output logic [7:0] rx_data_o
);

  localparam int CLKS  = `DBG_CLKS_PER_BIT;
  localparam int HALF  = CLKS / 2;
  localparam int CNT_W = $clog2(CLKS);

  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  logic             rxd_meta;
  logic             rxd_sync;
  logic             rxd_prev;
  logic [1:0]       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_q;
  logic [7:0]       shift_q;
  logic             bit_end;
  logic             sample_data;

  assign bit_end     = cnt_q == CNT_W'(CLKS - 1);
  assign sample_data = (state_q == RX_DATA) && bit_end;

  //////////////////////////////////////////////////
  // Synchronizer and frame FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rxd_meta   <= 1'b1;
      rxd_sync   <= 1'b1;
      rxd_prev   <= 1'b1;
      state_q    <= RX_IDLE;
      cnt_q      <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rxd_meta   <= rxd_i;
      rxd_sync   <= rxd_meta;
      rxd_prev   <= rxd_sync;
      rx_valid_o <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          // Falling edge marks a start bit
          if (rxd_prev && !rxd_sync) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (cnt_q == CNT_W'(HALF - 1)) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            // Glitch shorter than half a bit is dropped
            state_q <= rxd_sync ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          if (bit_end) begin
            // Framing error gives no strobe
            rx_valid_o <= rxd_sync;
            state_q    <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample_data) begin
      shift_q <= {rxd_sync, shift_q[7:1]};
    end
  end

  // Shift register is quiet until the next frame's first data bit
  assign rx_data_o = shift_q;

  a_rx_valid_single: assert property (
    @(posedge clk) disable iff (rst_i) rx_valid_o |=> !rx_valid_o
  ) else $error("rx_valid_o held for more than one cycle");

endmodule

`default_nettype wire

// File: hw/dbg_mem_if.sv
// Memory request bus between the command engine and the local byte memory
`timescale 1ns/1ps
`default_nettype none

`include "uart_debug_settings.svh"

interface dbg_mem_if;

  // Request side, one-cycle strobe
  logic                          req;
  logic                          we;
  logic [`DBG_MEM_ADDR_BITS-1:0] addr;
  logic [7:0]                    wdata;

  // Read data, valid the cycle after a read req
  logic [7:0]                    rdata;

  modport engine (
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport mem (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: hw/uart_debug_pkg.sv
// Protocol byte codes and header layout of the UART debug protocol
`default_nettype none

package uart_debug_pkg;

  //////////////////////////////////////////////////
  // Byte codes
  //////////////////////////////////////////////////

  // Commands from the host
  localparam logic [7:0] CMD_READ  = 8'h11;
  localparam logic [7:0] CMD_WRITE = 8'h12;

  // ACK doubles as the challenge byte and the reply
  localparam logic [7:0] BYTE_ACK  = 8'h06;
  localparam logic [7:0] BYTE_EOT  = 8'h04;

  //////////////////////////////////////////////////
  // Command header
  //////////////////////////////////////////////////

  // Both fields are sent least significant byte first
  localparam int HDR_ADDR_BYTES = 8;
  localparam int HDR_LEN_BYTES  = 8;

  // Only the low bits of the length are counted
  localparam int LEN_BITS = 16;

endpackage

`default_nettype wire

// File: hw/uart_debug_settings.svh
// Build-time settings of the UART debug server: bit timing and memory size
`ifndef UART_DEBUG_SETTINGS_SVH
`define UART_DEBUG_SETTINGS_SVH

//////////////////////////////////////////////////
// Serial timing
//////////////////////////////////////////////////

// Clock cycles per serial bit
`define DBG_CLKS_PER_BIT 16

//////////////////////////////////////////////////
// Local memory
//////////////////////////////////////////////////

// Memory holds 2**DBG_MEM_ADDR_BITS bytes, addresses wrap
`define DBG_MEM_ADDR_BITS 8

`endif
